//--- Makefile
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -Wno-fatal
TOP       := tb_hyper_fill_core
FILELIST  := vlog.f
OBJ_DIR   := obj_dir
SIM_BIN   := $(OBJ_DIR)/V$(TOP)
LOG       := sim.log
SOURCES   := $(wildcard verilog/*.sv) $(wildcard testbench/*.sv) $(wildcard testbench/*.svh)

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "TEST FAILED" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q "TEST PASSED" $(LOG); then echo "simulation ended early"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- testbench/tb_fill_model.svh
`ifndef TB_FILL_MODEL_SVH
`define TB_FILL_MODEL_SVH

localparam int ADDR_W = hyper_pkg::PAGE_W + hyper_pkg::COLL_W;

// words the DUT accepted, per channel, oldest first
hyper_pkg::lsab_entry_t chan_q [hyper_pkg::NUM_LSAB][$];

// entries held in each channel FIFO, accepted writes less buffer reads
int occ [hyper_pkg::NUM_LSAB] = '{default: 0};

int errors = 0;
int checks = 0;

// the transfer under check, latched from the issue inputs
int                 xfer_chan;
int                 xfer_count;
hyper_pkg::coll_t   xfer_start;
hyper_pkg::page_t   xfer_page;
int                 xfer_sent;
int                 acked;
bit                 eop_acked;
hyper_pkg::ancill_t eop_tag;
int                 rd_seen;
int                 irq_seen;

// last request that was left waiting for an acknowledge
bit                 held_q = 1'b0;
logic [ADDR_W-1:0]  held_addr;
hyper_pkg::word_t   held_data;

task automatic report_mismatch(string name, logic [63:0] got, logic [63:0] exp);
  $display("MISMATCH %s: got %0h, expected %0h at %0t", name, got, exp, $time);
  errors++;
endtask

task automatic report_failure(string what);
  $display("ERROR: %s at %0t", what, $time);
  errors++;
endtask

task automatic start_transfer(int chan, int count, hyper_pkg::coll_t start,
                              hyper_pkg::page_t page);
  xfer_chan  = chan;
  xfer_count = count;
  xfer_start = start;
  xfer_page  = page;
  xfer_sent  = 0;
  acked      = 0;
  eop_acked  = 1'b0;
  rd_seen    = 0;
  irq_seen   = 0;
endtask

task automatic check_hold(logic req, logic ack, logic [ADDR_W-1:0] addr,
                          hyper_pkg::word_t data);
  if (held_q)
  begin
    checks++;
    if (!req)
      report_failure("o_mem_req dropped before the request was acknowledged");
    if (addr !== held_addr)
      report_mismatch("o_mem_addr (held)", 64'(addr), 64'(held_addr));
    if (data !== held_data)
      report_mismatch("o_mem_data (held)", 64'(data), 64'(held_data));
  end
  held_q    = req && !ack;
  held_addr = addr;
  held_data = data;
endtask

task automatic check_ack(logic [ADDR_W-1:0] addr, hyper_pkg::word_t data);
  hyper_pkg::lsab_entry_t exp_e;
  logic [ADDR_W-1:0]      exp_addr;
  checks++;
  // the n-th word of a transfer lands at start plus n, the column wraps
  exp_addr = {xfer_page, hyper_pkg::coll_t'(xfer_start + acked)};
  if (addr !== exp_addr)
    report_mismatch("o_mem_addr", 64'(addr), 64'(exp_addr));
  if (chan_q[xfer_chan].size() == 0)
    report_failure($sformatf("write acknowledged but channel %0d has no word", xfer_chan));
  else
  begin
    exp_e = chan_q[xfer_chan].pop_front();
    if (data !== exp_e.data)
      report_mismatch("o_mem_data", 64'(data), 64'(exp_e.data));
    if (exp_e.eop)
    begin
      eop_acked = 1'b1;
      eop_tag   = exp_e.ancill;
    end
  end
  acked++;
endtask

task automatic close_transfer(hyper_pkg::count_t count_sent, hyper_pkg::ancill_t ancill);
  int                 exp_sent;
  int                 i;
  int                 extra;
  bit                 by_eop;
  hyper_pkg::ancill_t exp_tag;
  exp_sent = acked;
  by_eop   = eop_acked;
  exp_tag  = eop_tag;
  i        = 0;
  // words still queued in the port sit at the front of the channel queue
  while (!by_eop && exp_sent < xfer_count && i < chan_q[xfer_chan].size())
  begin
    if (chan_q[xfer_chan][i].eop)
    begin
      by_eop  = 1'b1;
      exp_tag = chan_q[xfer_chan][i].ancill;
    end
    exp_sent++;
    i++;
  end
  xfer_sent = exp_sent;
  checks++;
  if (int'(count_sent) != exp_sent)
    report_mismatch("o_count_sent", 64'(count_sent), 64'(exp_sent));
  if (by_eop && irq_seen != 1)
    report_failure($sformatf("o_irq pulsed %0d times for an end-flagged word", irq_seen));
  if (!by_eop && irq_seen != 0)
    report_failure($sformatf("o_irq pulsed %0d times with no end flag", irq_seen));
  if (by_eop && ancill !== exp_tag)
    report_mismatch("o_ancill", 64'(ancill), 64'(exp_tag));
  // a read issued beside the end-flagged word drains one word that is never sent
  extra = rd_seen - exp_sent;
  if (extra < 0 || extra > (by_eop ? 1 : 0))
    report_failure($sformatf("%0d buffer reads for %0d words sent", rd_seen, exp_sent));
  else if (extra == 1 && chan_q[xfer_chan].size() > i)
    chan_q[xfer_chan].delete(i);
endtask

`endif

//--- testbench/tb_hyper_fill_core.sv
`timescale 1ns/10ps

module tb_hyper_fill_core;

  localparam int N_XFER          = 40;
  localparam int CYCLES_PER_XFER = 200;
  localparam int CLK_PERIOD      = 4;
  localparam int FIFO_DEPTH      = 16;

  `include "tb_fill_model.svh"

  logic                                         CLK_n;
  logic                                         RST_MASTER;
  logic [hyper_pkg::NUM_LSAB-1:0]               i_write;
  hyper_pkg::word_t [hyper_pkg::NUM_LSAB-1:0]   i_data;
  hyper_pkg::ancill_t [hyper_pkg::NUM_LSAB-1:0] i_ancill;
  logic [hyper_pkg::NUM_LSAB-1:0]               i_int;
  logic [hyper_pkg::NUM_LSAB-1:0]               o_full;
  hyper_pkg::coll_t                             i_start_address;
  hyper_pkg::count_t                            i_count_req;
  hyper_pkg::chan_t                             i_section;
  logic                                         i_issue;
  hyper_pkg::page_t                             i_page_addr;
  logic                                         o_working;
  hyper_pkg::count_t                            o_count_sent;
  logic                                         o_irq;
  hyper_pkg::ancill_t                           o_ancill;
  logic                                         o_mem_req;
  logic [ADDR_W-1:0]                            o_mem_addr;
  hyper_pkg::word_t                             o_mem_data;
  logic                                         i_mem_ack;

  // falling-edge view of the DUT, read by the driver on the next rising edge
  logic [hyper_pkg::NUM_LSAB-1:0] full_q = '0;
  logic                           working_q = 1'b0;
  bit                             reset_checked = 1'b0;
  bit                             xfer_drained = 1'b0;
  int                             phase = 0;
  int                             cycle = 0;
  int                             stall_end = 0;

  hyper_fill_core #(
    .FIFO_DEPTH (FIFO_DEPTH)
  ) hyper_fill_core_i (.*);

  initial
  begin
    CLK_n = 1'b0;
    forever #(CLK_PERIOD / 2) CLK_n = ~CLK_n;
  end

  initial
  begin
    #(N_XFER * CYCLES_PER_XFER * CLK_PERIOD);
    $display("timeout: the transfers did not finish in time");
    $display("checks %0d, errors %0d", checks, errors);
    $display("*** TEST FAILED ***");
    $finish;
  end

  task automatic tick();
    @(posedge CLK_n);
    cycle++;
    for (int c = 0; c < hyper_pkg::NUM_LSAB; c++)
    begin
      i_write[c]  <= !full_q[c] && ($urandom % 4 == 0);
      i_data[c]   <= $urandom;
      i_ancill[c] <= hyper_pkg::ancill_t'($urandom);
      i_int[c]    <= ($urandom % 10 == 0);
    end
    // the memory gives no acknowledge at all inside a stall window
    if (cycle < stall_end)
      i_mem_ack <= 1'b0;
    else
      i_mem_ack <= ($urandom % 2 == 1);
  endtask

  task automatic run_transfer(int t);
    tick();
    i_start_address <= hyper_pkg::coll_t'($urandom);
    i_count_req     <= hyper_pkg::count_t'(1 + $urandom % 20);
    i_section       <= hyper_pkg::chan_t'($urandom);
    i_page_addr     <= hyper_pkg::page_t'($urandom);
    i_issue         <= 1'b1;
    if (t % 10 == 3)
      stall_end = cycle + 50;
    tick();
    i_issue <= 1'b0;
    while (!xfer_drained)
      tick();
  endtask

  initial
  begin
    void'($urandom(51938));
    RST_MASTER      <= 1'b1;
    i_write         <= '0;
    i_data          <= '0;
    i_ancill        <= '0;
    i_int           <= '0;
    i_start_address <= '0;
    i_count_req     <= '0;
    i_section       <= '0;
    i_issue         <= 1'b0;
    i_page_addr     <= '0;
    i_mem_ack       <= 1'b0;
    repeat (2) @(posedge CLK_n);
    RST_MASTER <= 1'b0;
    repeat (2) @(posedge CLK_n);
    for (int t = 0; t < N_XFER; t++)
      run_transfer(t);
    repeat (4) tick();
    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0)
      $display("*** TEST PASSED ***");
    else
      $display("*** TEST FAILED ***");
    $finish;
  end

  always @(negedge CLK_n)
  begin
    if (RST_MASTER === 1'b0)
    begin
      if (!reset_checked)
      begin
        checks++;
        if ({o_mem_req, o_working, o_irq, o_full} !== '0)
          report_mismatch("{o_mem_req,o_working,o_irq,o_full}",
                          64'({o_mem_req, o_working, o_irq, o_full}), 64'(0));
        reset_checked = 1'b1;
      end
      // a write counts only if the model finds the channel not full at that edge
      for (int c = 0; c < hyper_pkg::NUM_LSAB; c++)
      begin
        if (o_full[c] !== (occ[c] == FIFO_DEPTH))
          report_mismatch($sformatf("o_full[%0d]", c), 64'(o_full[c]),
                          64'(occ[c] == FIFO_DEPTH));
        if (i_write[c] && occ[c] < FIFO_DEPTH)
        begin
          chan_q[c].push_back(hyper_pkg::lsab_entry_t'{
            data: i_data[c], ancill: i_ancill[c], eop: i_int[c]});
          occ[c]++;
        end
        if (hyper_fill_core_i.rd_bus.rd &&
            hyper_fill_core_i.rd_bus.chan == hyper_pkg::chan_t'(c))
          occ[c]--;
      end
      check_hold(o_mem_req, i_mem_ack, o_mem_addr, o_mem_data);
      if (o_mem_req && i_mem_ack)
        check_ack(o_mem_addr, o_mem_data);
      if (hyper_fill_core_i.rd_bus.rd)
        rd_seen++;
      if (o_irq)
        irq_seen++;
      if (i_issue && !o_working)
      begin
        start_transfer(int'(i_section), int'(i_count_req), i_start_address, i_page_addr);
        phase        = 1;
        xfer_drained = 1'b0;
      end
      if (phase == 1 && working_q && !o_working)
      begin
        close_transfer(o_count_sent, o_ancill);
        phase = 2;
      end
      if (phase == 2 && !o_mem_req)
      begin
        checks++;
        if (acked != xfer_sent)
          report_failure($sformatf("%0d words reached memory, %0d were sent",
                                   acked, xfer_sent));
        phase        = 0;
        xfer_drained = 1'b1;
      end
      working_q = o_working;
      full_q    = o_full;
    end
  end

endmodule

//--- verilog/block_mover_fill.sv
`timescale 1ns/10ps

module block_mover_fill (
  input  logic               CLK_n,
  input  logic               RST_MASTER,
  input  hyper_pkg::coll_t   i_start_address,
  input  hyper_pkg::count_t  i_count_req,
  input  hyper_pkg::chan_t   i_section,
  input  logic               i_issue,
  output logic               o_working,
  output hyper_pkg::count_t  o_count_sent,
  output logic               o_irq,
  output hyper_pkg::ancill_t o_ancill,
  lsab_read_if.mover         rd_if,
  bulk_req_if.mover          req_if
);

  hyper_pkg::coll_t  start_q;
  hyper_pkg::count_t count_q;
  hyper_pkg::chan_t  section_q;
  hyper_pkg::count_t reads_issued;
  hyper_pkg::count_t words_sent;
  logic              end_seen;
  logic              sent_last;
  logic              done;

  assign rd_if.chan = section_q;

  // end_seen is registered, so the read issued alongside the eop word still goes out
  assign rd_if.rd = o_working && (reads_issued < count_q) && !end_seen &&
                    !rd_if.empty[section_q] && req_if.ready;

  // words returned after the end flag are read out of the buffer and dropped
  assign req_if.valid = rd_if.entry_valid && !end_seen;
  assign req_if.coll  = start_q + hyper_pkg::coll_t'(words_sent);
  assign req_if.data  = rd_if.entry.data;

  assign sent_last = req_if.valid && rd_if.entry.eop;

  // nothing may be in flight when the transfer closes
  assign done = o_working && !rd_if.entry_valid &&
                (end_seen || (words_sent == count_q));

  assign o_count_sent = words_sent;

  always_ff @(posedge CLK_n)
  begin
    if (RST_MASTER)
    begin
      o_working    <= 1'b0;
      o_irq        <= 1'b0;
      start_q      <= '0;
      count_q      <= '0;
      section_q    <= '0;
      reads_issued <= '0;
      words_sent   <= '0;
      end_seen     <= 1'b0;
    end
    else
    begin
      o_irq <= sent_last;
      if (!o_working && i_issue)
      begin
        start_q      <= i_start_address;
        count_q      <= i_count_req;
        section_q    <= i_section;
        reads_issued <= '0;
        words_sent   <= '0;
        end_seen     <= 1'b0;
        o_working    <= 1'b1;
      end
      else
      begin
        if (rd_if.rd)
          reads_issued <= reads_issued + 1'b1;
        if (req_if.valid)
          words_sent <= words_sent + 1'b1;
        if (sent_last)
          end_seen <= 1'b1;
        if (done)
          o_working <= 1'b0;
      end
    end
  end

  always_ff @(posedge CLK_n)
  begin
    if (sent_last)
      o_ancill <= rd_if.entry.ancill;
  end

  // a word from the buffer outside a transfer would mean a stray read
  a_valid_only_working: assert property (
    @(posedge CLK_n) disable iff (RST_MASTER)
    $rose(req_if.valid) |-> o_working
  );

endmodule

//--- verilog/bulk_req_if.sv
`timescale 1ns/10ps

interface bulk_req_if;

  logic             valid;
  hyper_pkg::coll_t coll;
  hyper_pkg::word_t data;
  logic             ready;

  // one valid cycle carries one word, there is no stall on valid itself
  modport mover (
    output valid,
    output coll,
    output data,
    input  ready
  );

  modport port (
    input  valid,
    input  coll,
    input  data,
    output ready
  );

endinterface

//--- verilog/bulk_write_port.sv
`timescale 1ns/10ps

module bulk_write_port (
  input  logic                                           CLK_n,
  input  logic                                           RST_MASTER,
  input  hyper_pkg::page_t                               i_page_addr,
  bulk_req_if.port                                       req_if,
  output logic                                           o_mem_req,
  output logic [hyper_pkg::PAGE_W+hyper_pkg::COLL_W-1:0] o_mem_addr,
  output hyper_pkg::word_t                               o_mem_data,
  input  logic                                           i_mem_ack
);

  localparam int QUEUE_DEPTH = 4;
  localparam int PTR_W = $clog2(QUEUE_DEPTH);
  localparam logic [PTR_W:0] READY_LEVEL = (PTR_W+1)'(QUEUE_DEPTH - 2);

  // the page is sampled with each word so a new transfer cannot alter queued requests
  hyper_pkg::page_t page_q [QUEUE_DEPTH];
  hyper_pkg::coll_t coll_q [QUEUE_DEPTH];
  hyper_pkg::word_t data_q [QUEUE_DEPTH];

  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [PTR_W:0]   level;
  logic             pop;

  // two free slots cover the word already on its way from the buffer
  assign req_if.ready = (level <= READY_LEVEL);

  assign o_mem_req  = (level != '0);
  assign o_mem_addr = {page_q[rd_ptr], coll_q[rd_ptr]};
  assign o_mem_data = data_q[rd_ptr];
  assign pop        = o_mem_req && i_mem_ack;

  always_ff @(posedge CLK_n)
  begin
    if (RST_MASTER)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      level  <= '0;
    end
    else
    begin
      if (req_if.valid)
        wr_ptr <= wr_ptr + 1'b1;
      if (pop)
        rd_ptr <= rd_ptr + 1'b1;
      case ({req_if.valid, pop})
        2'b10:   level <= level + 1'b1;
        2'b01:   level <= level - 1'b1;
        default: level <= level;
      endcase
    end
  end

  always_ff @(posedge CLK_n)
  begin
    if (req_if.valid)
    begin
      page_q[wr_ptr] <= i_page_addr;
      coll_q[wr_ptr] <= req_if.coll;
      data_q[wr_ptr] <= req_if.data;
    end
  end

  a_hold_until_ack: assert property (
    @(posedge CLK_n) disable iff (RST_MASTER)
    (o_mem_req && !i_mem_ack) |=>
      (o_mem_req && $stable(o_mem_addr) && $stable(o_mem_data))
  );

endmodule

//--- verilog/hyper_fill_core.sv
`timescale 1ns/10ps

module hyper_fill_core #(
  parameter int FIFO_DEPTH = 16
) (
  input  logic                                           CLK_n,
  input  logic                                           RST_MASTER,
  input  logic [hyper_pkg::NUM_LSAB-1:0]                 i_write,
  input  hyper_pkg::word_t [hyper_pkg::NUM_LSAB-1:0]     i_data,
  input  hyper_pkg::ancill_t [hyper_pkg::NUM_LSAB-1:0]   i_ancill,
  input  logic [hyper_pkg::NUM_LSAB-1:0]                 i_int,
  output logic [hyper_pkg::NUM_LSAB-1:0]                 o_full,
  input  hyper_pkg::coll_t                               i_start_address,
  input  hyper_pkg::count_t                              i_count_req,
  input  hyper_pkg::chan_t                               i_section,
  input  logic                                           i_issue,
  input  hyper_pkg::page_t                               i_page_addr,
  output logic                                           o_working,
  output hyper_pkg::count_t                              o_count_sent,
  output logic                                           o_irq,
  output hyper_pkg::ancill_t                             o_ancill,
  output logic                                           o_mem_req,
  output logic [hyper_pkg::PAGE_W+hyper_pkg::COLL_W-1:0] o_mem_addr,
  output hyper_pkg::word_t                               o_mem_data,
  input  logic                                           i_mem_ack
);

  lsab_read_if rd_bus ();
  bulk_req_if  req_bus ();

  lsab_in_buffer #(
    .FIFO_DEPTH (FIFO_DEPTH)
  ) lsab_in_buffer_i (
    .CLK_n      (CLK_n),
    .RST_MASTER (RST_MASTER),
    .i_write    (i_write),
    .i_data     (i_data),
    .i_ancill   (i_ancill),
    .i_int      (i_int),
    .o_full     (o_full),
    .rd_if      (rd_bus.buffer)
  );

  block_mover_fill block_mover_fill_i (
    .CLK_n           (CLK_n),
    .RST_MASTER      (RST_MASTER),
    .i_start_address (i_start_address),
    .i_count_req     (i_count_req),
    .i_section       (i_section),
    .i_issue         (i_issue),
    .o_working       (o_working),
    .o_count_sent    (o_count_sent),
    .o_irq           (o_irq),
    .o_ancill        (o_ancill),
    .rd_if           (rd_bus.mover),
    .req_if          (req_bus.mover)
  );

  bulk_write_port bulk_write_port_i (
    .CLK_n       (CLK_n),
    .RST_MASTER  (RST_MASTER),
    .i_page_addr (i_page_addr),
    .req_if      (req_bus.port),
    .o_mem_req   (o_mem_req),
    .o_mem_addr  (o_mem_addr),
    .o_mem_data  (o_mem_data),
    .i_mem_ack   (i_mem_ack)
  );

endmodule

//--- verilog/hyper_pkg.sv
package hyper_pkg;

  // four producer channels feed the inbound path
  parameter int NUM_LSAB = 4;

  parameter int WORD_W   = 32;
  parameter int ANCILL_W = 25;

  // a DRAM address is a page followed by a column
  parameter int COLL_W   = 9;
  parameter int PAGE_W   = 17;

  parameter int COUNT_W  = 6;
  parameter int CHAN_W   = 2;

  typedef logic [WORD_W-1:0]   word_t;
  typedef logic [ANCILL_W-1:0] ancill_t;
  typedef logic [COLL_W-1:0]   coll_t;
  typedef logic [PAGE_W-1:0]   page_t;
  typedef logic [COUNT_W-1:0]  count_t;
  typedef logic [CHAN_W-1:0]   chan_t;

  // one buffered word with its tag
  // eop marks the last word of a packet and ends a transfer early
  typedef struct packed {
    word_t   data;
    ancill_t ancill;
    logic    eop;
  } lsab_entry_t;

endpackage

//--- verilog/lsab_in_buffer.sv
`timescale 1ns/10ps

module lsab_in_buffer #(
  parameter int FIFO_DEPTH = 16
) (
  input  logic                                       CLK_n,
  input  logic                                       RST_MASTER,
  input  logic [hyper_pkg::NUM_LSAB-1:0]             i_write,
  input  hyper_pkg::word_t [hyper_pkg::NUM_LSAB-1:0]   i_data,
  input  hyper_pkg::ancill_t [hyper_pkg::NUM_LSAB-1:0] i_ancill,
  input  logic [hyper_pkg::NUM_LSAB-1:0]             i_int,
  output logic [hyper_pkg::NUM_LSAB-1:0]             o_full,
  lsab_read_if.buffer                                rd_if
);

  localparam int PTR_W = $clog2(FIFO_DEPTH);
  localparam logic [PTR_W:0] FULL_LEVEL = (PTR_W+1)'(FIFO_DEPTH);

  hyper_pkg::lsab_entry_t store [hyper_pkg::NUM_LSAB][FIFO_DEPTH];

  logic [PTR_W-1:0] wr_ptr [hyper_pkg::NUM_LSAB];
  logic [PTR_W-1:0] rd_ptr [hyper_pkg::NUM_LSAB];
  logic [PTR_W:0]   fill   [hyper_pkg::NUM_LSAB];

  logic [hyper_pkg::NUM_LSAB-1:0] push;
  logic [hyper_pkg::NUM_LSAB-1:0] pop;

  always_comb
  begin
    for (int c = 0; c < hyper_pkg::NUM_LSAB; c++)
    begin
      o_full[c]      = (fill[c] == FULL_LEVEL);
      rd_if.empty[c] = (fill[c] == '0);
      // a write into a full channel is simply dropped
      push[c]        = i_write[c] && !o_full[c];
      pop[c]         = rd_if.rd && (rd_if.chan == hyper_pkg::chan_t'(c));
    end
  end

  always_ff @(posedge CLK_n)
  begin
    if (RST_MASTER)
    begin
      for (int c = 0; c < hyper_pkg::NUM_LSAB; c++)
      begin
        wr_ptr[c] <= '0;
        rd_ptr[c] <= '0;
        fill[c]   <= '0;
      end
      rd_if.entry_valid <= 1'b0;
    end
    else
    begin
      for (int c = 0; c < hyper_pkg::NUM_LSAB; c++)
      begin
        if (push[c])
          wr_ptr[c] <= wr_ptr[c] + 1'b1;
        if (pop[c])
          rd_ptr[c] <= rd_ptr[c] + 1'b1;
        case ({push[c], pop[c]})
          2'b10:   fill[c] <= fill[c] + 1'b1;
          2'b01:   fill[c] <= fill[c] - 1'b1;
          default: fill[c] <= fill[c];
        endcase
      end
      rd_if.entry_valid <= rd_if.rd;
    end
  end

  // channel storage, and the entry register loaded from the chosen channel on rd
  always_ff @(posedge CLK_n)
  begin
    for (int c = 0; c < hyper_pkg::NUM_LSAB; c++)
    begin
      if (push[c])
      begin
        store[c][wr_ptr[c]] <= hyper_pkg::lsab_entry_t'{
          data:   i_data[c],
          ancill: i_ancill[c],
          eop:    i_int[c]
        };
      end
    end
    if (rd_if.rd)
      rd_if.entry <= store[rd_if.chan][rd_ptr[rd_if.chan]];
  end

  // the mover has to check empty before it reads, otherwise the pointers slip
  a_no_read_when_empty: assert property (
    @(posedge CLK_n) disable iff (RST_MASTER)
    rd_if.rd |-> !rd_if.empty[rd_if.chan]
  );

endmodule

//--- verilog/lsab_read_if.sv
`timescale 1ns/10ps

interface lsab_read_if;

  logic                           rd;
  hyper_pkg::chan_t               chan;
  logic [hyper_pkg::NUM_LSAB-1:0] empty;
  logic                           entry_valid;
  hyper_pkg::lsab_entry_t         entry;

  // entry and entry_valid follow rd by exactly one cycle
  modport buffer (
    input  rd,
    input  chan,
    output empty,
    output entry_valid,
    output entry
  );

  modport mover (
    output rd,
    output chan,
    input  empty,
    input  entry_valid,
    input  entry
  );

endinterface

//--- vlog.f
+incdir+testbench
verilog/hyper_pkg.sv
verilog/lsab_read_if.sv
verilog/bulk_req_if.sv
verilog/lsab_in_buffer.sv
verilog/block_mover_fill.sv
verilog/bulk_write_port.sv
verilog/hyper_fill_core.sv
testbench/tb_hyper_fill_core.sv
